// File: test/frames_input.txt
# name gap(0 = random) accepted len_err drop_inc nbytes, then 12 expected cmd bytes
# followed by the frame bytes in hex, destination mac first
valid12 0 1 0 0 54 01 02 03 04 05 06 07 08 09 0a 0b 0c
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 01 02 03 04 05 06 07 08 09 0a 0b 0c
bad_mac 0 0 0 0 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c1 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 11 12 13 14 15 16 17 18 19 1a 1b 1c
bad_type 0 0 0 0 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 06
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 11 12 13 14 15 16 17 18 19 1a 1b 1c
bad_proto 0 0 0 0 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 06 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 11 12 13 14 15 16 17 18 19 1a 1b 1c
bad_ip 0 0 0 0 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 03
04 d2 1f 90 00 14 00 00 11 12 13 14 15 16 17 18 19 1a 1b 1c
bad_port 0 0 0 0 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 91 00 14 00 00 11 12 13 14 15 16 17 18 19 1a 1b 1c
bcast 0 1 0 0 54 21 22 23 24 25 26 27 28 29 2a 2b 2c
ff ff ff ff ff ff 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 21 22 23 24 25 26 27 28 29 2a 2b 2c
len8_pad 0 1 1 0 60 a1 a2 a3 a4 a5 a6 a7 a8 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 24 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 10 00 00 a1 a2 a3 a4 a5 a6 a7 a8 00 00 00 00 00 00 00 00 00 00
len20 0 1 1 0 62 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 30 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 1c 00 00 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf c0 c1 c2 c3
short 0 0 0 0 48 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 51 52 53 54 55 56
after_short 0 1 0 0 54 31 32 33 34 35 36 37 38 39 3a 3b 3c
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 31 32 33 34 35 36 37 38 39 3a 3b 3c
busy_first 0 1 0 0 54 41 42 43 44 45 46 47 48 49 4a 4b 4c
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 41 42 43 44 45 46 47 48 49 4a 4b 4c
busy_second 10 0 0 1 54 00 00 00 00 00 00 00 00 00 00 00 00
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 61 62 63 64 65 66 67 68 69 6a 6b 6c
final12 0 1 0 0 54 71 72 73 74 75 76 77 78 79 7a 7b 7c
00 0a 35 01 fe c0 00 0a 35 00 00 01 08 00
45 00 00 28 00 00 40 00 40 11 00 00 c0 a8 00 01 c0 a8 00 02
04 d2 1f 90 00 14 00 00 71 72 73 74 75 76 77 78 79 7a 7b 7c

// File: src.f
verilog/udp_cmd_pkg.sv
verilog/udp_rx.sv
verilog/payload_fifo.sv
verilog/rx_sequencer.sv
verilog/cmd_unpack.sv
verilog/udp_cmd_top.sv
test/udp_cmd_checker.sv
test/udp_cmd_assertions.sv
test/tb_udp_cmd.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_udp_cmd
FILELIST  := src.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run test clean

all: test

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)

test: run
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/tb_udp_cmd.sv
`timescale 1ns/1ps

module tb_udp_cmd;

    logic sys_clk;
    logic rst;
    logic mac_rxdv;
    logic [7:0] mac_rxd;
    logic cmd_valid;
    udp_cmd_pkg::udp_cmd_t cmd;
    logic len_err;
    logic [15:0] drop_count;
    logic [udp_cmd_pkg::FIFO_AW:0] fifo_count;
    int checked;
    int pass_count;
    int fail_count;
    int limit_cycles;
    logic [31:0] seed;

    // one entry per test and the frame bytes of all tests back to back
    string names[$];
    int gaps[$];
    int lens[$];
    logic accs[$];
    logic lerrs[$];
    int drops[$];
    udp_cmd_pkg::udp_cmd_t cmds[$];
    logic [7:0] frame_bytes[$];

    udp_cmd_top i_dut (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .mac_rxdv   (mac_rxdv),
        .mac_rxd    (mac_rxd),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .len_err    (len_err),
        .drop_count (drop_count),
        .fifo_count (fifo_count)
    );

    udp_cmd_checker i_checker (
        .sys_clk    (sys_clk),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .len_err    (len_err),
        .drop_count (drop_count),
        .fifo_count (fifo_count),
        .checked    (checked),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic read_file(output bit ok);
        int fd;
        int r;
        int gap;
        int acc;
        int lerr;
        int drop;
        int n;
        logic [7:0] b;
        logic [95:0] exp;
        string tok;
        string line;
        ok = 0;
        fd = $fopen("test/frames_input.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", tok);
                if (r != 1) begin
                    break;
                end
                if (tok.substr(0, 0) == "#") begin
                    r = $fgets(line, fd);
                end else begin
                    r = $fscanf(fd, "%d %d %d %d %d", gap, acc, lerr, drop, n);
                    for (int k = 0; k < 12; k++) begin
                        r = $fscanf(fd, "%h", b);
                        exp[95-8*k -: 8] = b;
                    end
                    for (int k = 0; k < n; k++) begin
                        r = $fscanf(fd, "%h", b);
                        frame_bytes.push_back(b);
                    end
                    // a zero gap in the file means pick one at random
                    if (gap == 0) begin
                        seed = xorshift(seed);
                        gap = 80 + int'(seed % 48);
                    end
                    names.push_back(tok);
                    gaps.push_back(gap);
                    lens.push_back(n);
                    accs.push_back(acc != 0);
                    lerrs.push_back(lerr != 0);
                    drops.push_back(drop);
                    cmds.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_frame(input int idx, input int first);
        for (int k = 0; k < lens[idx]; k++) begin
            @(posedge sys_clk);
            mac_rxdv <= 1'b1;
            mac_rxd <= frame_bytes[first+k];
        end
        @(posedge sys_clk);
        mac_rxdv <= 1'b0;
        mac_rxd <= 8'h00;
        i_checker.name_q.push_back(names[idx]);
        i_checker.accept_q.push_back(accs[idx]);
        i_checker.len_err_q.push_back(lerrs[idx]);
        i_checker.cmd_q.push_back(cmds[idx]);
        i_checker.drop_q.push_back(drops[idx]);
    endtask

    // watchdog armed once the file length is known
    initial begin
        limit_cycles = 0;
        wait (limit_cycles != 0);
        #(limit_cycles * 8);
        $display("timeout: no final result after %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit ok;
        int first;
        int total;
        int assert_errs;
        rst = 1'b1;
        mac_rxdv = 1'b0;
        mac_rxd = 8'h00;
        seed = 32'ha871_2637;
        read_file(ok);
        if (!ok || names.size() == 0) begin
            $display("could not read any test from test/frames_input.txt");
            $display("TEST FAILED");
        end else begin
            total = 200 + 3;
            foreach (lens[i]) begin
                total += lens[i] + gaps[i];
            end
            limit_cycles = total;
            repeat (3) @(posedge sys_clk);
            rst <= 1'b0;
            first = 0;
            foreach (names[i]) begin
                repeat (gaps[i]) @(posedge sys_clk);
                send_frame(i, first);
                first += lens[i];
            end
            wait (checked == names.size());
            assert_errs = i_dut.i_rx_sequencer.i_seq_assertions.err_count;
            $display("summary: %0d passed, %0d failed, %0d assertion errors",
                     pass_count, fail_count, assert_errs);
            if (fail_count == 0 && assert_errs == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

// File: test/udp_cmd_assertions.sv
`timescale 1ns/1ps

module udp_cmd_assertions (
    input logic sys_clk,
    input logic rst,
    input logic rx_done,
    input logic done,
    input logic busy,
    input logic start
);

    // number of assertion failures so far
    int err_count = 0;

    start_from_idle: assert property (@(posedge sys_clk) disable iff (rst)
        start |-> !$past(busy))
        else begin
            $error("start issued while busy was already high");
            err_count++;
        end

    done_frees_path: assert property (@(posedge sys_clk) disable iff (rst)
        done |=> !busy)
        else begin
            $error("busy still high the cycle after done");
            err_count++;
        end

    no_frame_while_busy: assert property (@(posedge sys_clk) disable iff (rst)
        rx_done |-> !busy)
        else begin
            $error("rx_done arrived while the receive path was busy");
            err_count++;
        end

endmodule

bind rx_sequencer udp_cmd_assertions i_seq_assertions (
    .sys_clk (sys_clk),
    .rst     (rst),
    .rx_done (rx_done),
    .done    (done),
    .busy    (busy),
    .start   (start)
);

// File: test/udp_cmd_checker.sv
`timescale 1ns/1ps

module udp_cmd_checker (
    input  logic                          sys_clk,
    input  logic                          cmd_valid,
    input  udp_cmd_pkg::udp_cmd_t         cmd,
    input  logic                          len_err,
    input  logic [15:0]                   drop_count,
    input  logic [udp_cmd_pkg::FIFO_AW:0] fifo_count,
    output int                            checked,
    output int                            pass_count,
    output int                            fail_count
);

    // cycles after a frame ends in which its command must show up
    localparam int WINDOW = 60;

    // expected records, pushed by the driver as each frame ends
    string name_q[$];
    logic accept_q[$];
    logic len_err_q[$];
    udp_cmd_pkg::udp_cmd_t cmd_q[$];
    int drop_q[$];
    int exp_drop;

    task automatic check_one();
        string name;
        logic acc;
        logic lerr;
        logic [95:0] exp_bits;
        logic [95:0] got_bits;
        int seen;
        int errs;
        name = name_q.pop_front();
        acc = accept_q.pop_front();
        lerr = len_err_q.pop_front();
        exp_bits = cmd_q.pop_front();
        exp_drop += drop_q.pop_front();
        seen = 0;
        errs = 0;
        // drop counter moves on the first byte, so it is settled by now
        if (drop_count != 16'(exp_drop)) begin
            $display("ERR %0t drop_count exp %0d got %0d", $time, exp_drop, drop_count);
            errs++;
        end
        repeat (WINDOW) begin
            @(negedge sys_clk);
            if (cmd_valid) begin
                seen++;
                got_bits = cmd;
                if (acc && seen == 1) begin
                    for (int k = 0; k < udp_cmd_pkg::CMD_BYTES; k++) begin
                        if (got_bits[95-8*k -: 8] != exp_bits[95-8*k -: 8]) begin
                            $display("ERR %0t cmd[%0d] exp %h got %h", $time, k,
                                     exp_bits[95-8*k -: 8], got_bits[95-8*k -: 8]);
                            errs++;
                        end
                    end
                    if (len_err != lerr) begin
                        $display("ERR %0t len_err exp %b got %b", $time, lerr, len_err);
                        errs++;
                    end
                end
            end
        end
        if (acc && seen == 0) begin
            $display("%s: accepted frame produced no cmd_valid", name);
            errs++;
        end else if (!acc && seen != 0) begin
            $display("%s: rejected frame produced a cmd_valid", name);
            errs++;
        end else if (seen > 1) begin
            $display("%s: more than one cmd_valid for one frame", name);
            errs++;
        end
        if (fifo_count != 0) begin
            $display("ERR %0t fifo_count exp 0 got %0d", $time, fifo_count);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: fail with %0d errors", name, errs);
        end
        checked++;
    endtask

    initial begin
        checked = 0;
        pass_count = 0;
        fail_count = 0;
        exp_drop = 0;
        forever begin
            @(negedge sys_clk);
            if (name_q.size() != 0) begin
                check_one();
            end
        end
    end

endmodule

// File: verilog/udp_cmd_top.sv
`timescale 1ns/1ps

module udp_cmd_top (
    input  logic                          sys_clk,
    input  logic                          rst,
    input  logic                          mac_rxdv,
    input  logic [7:0]                    mac_rxd,
    output logic                          cmd_valid,
    output udp_cmd_pkg::udp_cmd_t         cmd,
    output logic                          len_err,
    output logic [15:0]                   drop_count,
    output logic [udp_cmd_pkg::FIFO_AW:0] fifo_count
);

    logic wr_en;
    logic [7:0] wr_data;
    logic flush;
    logic rx_done;
    udp_cmd_pkg::rx_frame_t rx_frame;
    logic busy;
    logic start;
    udp_cmd_pkg::rx_frame_t job;
    logic done;
    logic rd_en;
    logic [7:0] rd_data;

    udp_rx i_udp_rx (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .mac_rxdv   (mac_rxdv),
        .mac_rxd    (mac_rxd),
        .busy       (busy),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .flush      (flush),
        .rx_done    (rx_done),
        .rx_frame   (rx_frame),
        .drop_count (drop_count)
    );

    payload_fifo i_payload_fifo (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .flush      (flush),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .data_count (fifo_count)
    );

    rx_sequencer i_rx_sequencer (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .rx_done  (rx_done),
        .rx_frame (rx_frame),
        .done     (done),
        .busy     (busy),
        .start    (start),
        .job      (job)
    );

    cmd_unpack i_cmd_unpack (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .start     (start),
        .job       (job),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .done      (done),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .len_err   (len_err)
    );

endmodule

// File: verilog/cmd_unpack.sv
`timescale 1ns/1ps

module cmd_unpack (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   start,
    input  udp_cmd_pkg::rx_frame_t job,
    input  logic [7:0]             rd_data,
    output logic                   rd_en,
    output logic                   done,
    output logic                   cmd_valid,
    output udp_cmd_pkg::udp_cmd_t  cmd,
    output logic                   len_err
);

    logic reading;
    logic [udp_cmd_pkg::LEN_W-1:0] len_q;
    logic [udp_cmd_pkg::LEN_W-1:0] rd_cnt;
    // index of the byte arriving on rd_data
    logic [udp_cmd_pkg::LEN_W-1:0] idx_d;
    logic rd_last;
    logic valid_d;
    logic last_d;
    logic fin;
    logic [0:udp_cmd_pkg::CMD_BYTES-1][7:0] cmd_bytes;

    assign rd_en = reading;
    assign rd_last = reading && (rd_cnt == len_q - 1'b1);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            reading <= 1'b0;
            rd_cnt <= '0;
            valid_d <= 1'b0;
            last_d <= 1'b0;
            fin <= 1'b0;
        end else begin
            if (start) begin
                reading <= 1'b1;
                rd_cnt <= '0;
            end else if (reading) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_last) begin
                    reading <= 1'b0;
                end
            end
            valid_d <= rd_en;
            last_d <= rd_last;
            // last byte lands in cmd_bytes on this same edge
            fin <= valid_d && last_d;
        end
    end

    always_ff @(posedge sys_clk) begin
        idx_d <= rd_cnt;
        if (start) begin
            len_q <= job.len;
            // unused fields read as zero
            cmd_bytes <= '0;
        end else if (valid_d && idx_d < udp_cmd_pkg::CMD_BYTES) begin
            cmd_bytes[idx_d[3:0]] <= rd_data;
        end
    end

    assign cmd = udp_cmd_pkg::udp_cmd_t'(cmd_bytes);
    assign len_err = (len_q != udp_cmd_pkg::LEN_W'(udp_cmd_pkg::CMD_BYTES));
    assign cmd_valid = fin;
    assign done = fin;

endmodule

// File: verilog/rx_sequencer.sv
`timescale 1ns/1ps

module rx_sequencer (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   rx_done,
    input  udp_cmd_pkg::rx_frame_t rx_frame,
    input  logic                   done,
    output logic                   busy,
    output logic                   start,
    output udp_cmd_pkg::rx_frame_t job
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        WAIT
    } state_t;

    state_t state;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (rx_done) begin
                        state <= START;
                    end
                end
                START: state <= WAIT;
                WAIT: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == IDLE && rx_done) begin
            job <= rx_frame;
        end
    end

    // fifo holds one frame at a time, keep udp_rx out until it is drained
    assign busy = (state != IDLE);
    assign start = (state == START);

endmodule

// File: verilog/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo (
    input  logic                          sys_clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          wr_en,
    input  logic [7:0]                    wr_data,
    input  logic                          rd_en,
    output logic [7:0]                    rd_data,
    output logic [udp_cmd_pkg::FIFO_AW:0] data_count
);

    logic [7:0] mem [udp_cmd_pkg::FIFO_DEPTH];
    // one extra bit tells full from empty
    logic [udp_cmd_pkg::FIFO_AW:0] wr_ptr;
    logic [udp_cmd_pkg::FIFO_AW:0] rd_ptr;
    logic full;
    logic empty;
    logic do_wr;
    logic do_rd;

    assign data_count = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full = data_count[udp_cmd_pkg::FIFO_AW];
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // registered read, data the cycle after rd_en
    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr[udp_cmd_pkg::FIFO_AW-1:0]] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr[udp_cmd_pkg::FIFO_AW-1:0]];
        end
    end

endmodule

// File: verilog/udp_rx.sv
`timescale 1ns/1ps

module udp_rx (
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic                   mac_rxdv,
    input  logic [7:0]             mac_rxd,
    input  logic                   busy,
    output logic                   wr_en,
    output logic [7:0]             wr_data,
    output logic                   flush,
    output logic                   rx_done,
    output udp_cmd_pkg::rx_frame_t rx_frame,
    output logic [15:0]            drop_count
);

    // position of the byte on mac_rxd, zero between frames
    logic [udp_cmd_pkg::LEN_W:0] pos;
    logic rxdv_d;
    logic ignore;
    logic reject;
    logic mac_loc_bad;
    logic mac_bc_bad;
    logic [15:0] udp_len;
    logic [udp_cmd_pkg::LEN_W-1:0] pay_len;
    logic [udp_cmd_pkg::LEN_W-1:0] wr_cnt;
    logic [7:0] mac_loc_byte;
    logic [7:0] hdr_exp;
    logic hdr_chk;
    logic hdr_ok;
    logic frame_ok;
    logic frame_end;
    logic pay_wr;

    always_comb begin
        case (pos)
            0: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[47:40];
            1: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[39:32];
            2: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[31:24];
            3: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[23:16];
            4: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[15:8];
            5: mac_loc_byte = udp_cmd_pkg::LOCAL_MAC[7:0];
            default: mac_loc_byte = 8'h00;
        endcase
    end

    // fixed header bytes that must match exactly
    always_comb begin
        hdr_chk = 1'b1;
        case (pos)
            12: hdr_exp = udp_cmd_pkg::ETHERTYPE_IPV4[15:8];
            13: hdr_exp = udp_cmd_pkg::ETHERTYPE_IPV4[7:0];
            23: hdr_exp = udp_cmd_pkg::IP_PROTO_UDP;
            30: hdr_exp = udp_cmd_pkg::LOCAL_IP[31:24];
            31: hdr_exp = udp_cmd_pkg::LOCAL_IP[23:16];
            32: hdr_exp = udp_cmd_pkg::LOCAL_IP[15:8];
            33: hdr_exp = udp_cmd_pkg::LOCAL_IP[7:0];
            36: hdr_exp = udp_cmd_pkg::LOCAL_PORT[15:8];
            37: hdr_exp = udp_cmd_pkg::LOCAL_PORT[7:0];
            default: begin
                hdr_chk = 1'b0;
                hdr_exp = 8'h00;
            end
        endcase
    end

    // udp length includes its own 8 byte header
    assign pay_len = udp_len[udp_cmd_pkg::LEN_W-1:0] - udp_cmd_pkg::LEN_W'(8);

    // mac matches if either the local or the broadcast compare held
    assign hdr_ok = !reject && !(mac_loc_bad && mac_bc_bad);
    assign frame_ok = !ignore && hdr_ok && (pos >= udp_cmd_pkg::HDR_BYTES);
    assign frame_end = rxdv_d && !mac_rxdv;

    // padding after the declared payload is dropped here
    assign pay_wr = mac_rxdv && (pos >= udp_cmd_pkg::HDR_BYTES) && !ignore && hdr_ok
                    && (wr_cnt != pay_len);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            pos <= '0;
            rxdv_d <= 1'b0;
            ignore <= 1'b0;
            reject <= 1'b0;
            mac_loc_bad <= 1'b0;
            mac_bc_bad <= 1'b0;
            wr_cnt <= '0;
            wr_en <= 1'b0;
            flush <= 1'b0;
            rx_done <= 1'b0;
            drop_count <= '0;
        end else begin
            rxdv_d <= mac_rxdv;
            wr_en <= pay_wr;
            rx_done <= frame_end && frame_ok && (wr_cnt == pay_len);
            // short frame, throw away what was written
            flush <= frame_end && frame_ok && (wr_cnt != pay_len);

            if (!mac_rxdv) begin
                pos <= '0;
            end else if (pos != '1) begin
                pos <= pos + 1'b1;
            end

            if (mac_rxdv && pos == '0) begin
                // rx_done is the cycle before busy rises
                ignore <= busy || rx_done;
                reject <= 1'b0;
                mac_loc_bad <= (mac_rxd != mac_loc_byte);
                mac_bc_bad <= (mac_rxd != 8'hFF);
                wr_cnt <= '0;
                if (busy || rx_done) begin
                    drop_count <= drop_count + 1'b1;
                end
            end else if (mac_rxdv) begin
                if (pos < 6) begin
                    mac_loc_bad <= mac_loc_bad || (mac_rxd != mac_loc_byte);
                    mac_bc_bad <= mac_bc_bad || (mac_rxd != 8'hFF);
                end
                if (hdr_chk && mac_rxd != hdr_exp) begin
                    reject <= 1'b1;
                end
                // empty or oversized payload
                if (pos == 40 && (udp_len < 16'd9 ||
                        udp_len > 16'(udp_cmd_pkg::FIFO_DEPTH + 7))) begin
                    reject <= 1'b1;
                end
                if (pay_wr) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        wr_data <= mac_rxd;
        if (mac_rxdv && pos == 38) begin
            udp_len[15:8] <= mac_rxd;
        end
        if (mac_rxdv && pos == 39) begin
            udp_len[7:0] <= mac_rxd;
        end
        if (frame_end) begin
            rx_frame.len <= pay_len;
        end
    end

endmodule

// File: verilog/udp_cmd_pkg.sv
package udp_cmd_pkg;

    // board identity
    localparam logic [47:0] LOCAL_MAC = 48'h00_0A_35_01_FE_C0;
    localparam logic [31:0] LOCAL_IP = 32'hC0_A8_00_02;
    localparam logic [15:0] LOCAL_PORT = 16'd8080;

    // header field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    // 14 ethernet + 20 ip + 8 udp
    localparam int HDR_BYTES = 42;
    localparam int CMD_BYTES = 12;

    localparam int LEN_W = 11;
    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_AW = 11;

    // one received frame, payload length only
    typedef struct packed {
        logic [LEN_W-1:0] len;
    } rx_frame_t;

    // device command, first payload byte at the top
    typedef struct packed {
        logic [7:0] dev_info;
        logic [7:0] dev_kind;
        logic [7:0] dev_smpr;
        logic [7:0] cmd_kdev;
        logic [7:0] cmd_smpr;
        logic [7:0] cmd_filt;
        logic [7:0] cmd_mix0;
        logic [7:0] cmd_mix1;
        logic [7:0] cmd_reg4;
        logic [7:0] cmd_reg5;
        logic [7:0] cmd_reg6;
        logic [7:0] cmd_reg7;
    } udp_cmd_t;

endpackage
